//--- flist.f
+incdir+include
hdl/mini_rv_pkg.sv
hdl/gpr_ctl.sv
hdl/rv_decode.sv
hdl/rv_alu.sv
hdl/host_regs.sv
hdl/mini_rv_top.sv
testbench/tb_mini_rv.sv

//--- hdl/gpr_ctl.sv
// 31 x 32 bit general purpose registers, x0 hardwired to zero
// two and-or read ports, two write ports
`timescale 1ns/100ps
`include "mini_rv_defines.svh"

module gpr_ctl (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic [`MINI_RV_RA_W-1:0] raddr0,   // rs1 side
   input  logic [`MINI_RV_RA_W-1:0] raddr1,   // rs2 or peek side
   input  logic                     wen0,     // execute write-back
   input  logic [`MINI_RV_RA_W-1:0] waddr0,
   input  logic [`MINI_RV_XLEN-1:0] wd0,
   input  logic                     wen1,     // host poke
   input  logic [`MINI_RV_RA_W-1:0] waddr1,
   input  logic [`MINI_RV_XLEN-1:0] wd1,
   output logic [`MINI_RV_XLEN-1:0] rd0,
   output logic [`MINI_RV_XLEN-1:0] rd1
);

   logic [31:1][`MINI_RV_XLEN-1:0] gpr_q;  // x1..x31
   logic [31:1]                    w0v;    // port 0 hits
   logic [31:1]                    w1v;    // port 1 hits

   // and-or read, nothing selected for x0
   always_comb begin
      rd0 = '0;
      rd1 = '0;
      for (int j = 1; j < 32; j++) begin
         rd0 |= {`MINI_RV_XLEN{raddr0 == j[`MINI_RV_RA_W-1:0]}} & gpr_q[j];
         rd1 |= {`MINI_RV_XLEN{raddr1 == j[`MINI_RV_RA_W-1:0]}} & gpr_q[j];
      end
   end

   // per register write hit decode
   always_comb begin
      for (int j = 1; j < 32; j++) begin
         w0v[j] = wen0 && (waddr0 == j[`MINI_RV_RA_W-1:0]);
         w1v[j] = wen1 && (waddr1 == j[`MINI_RV_RA_W-1:0]);
      end
   end

   always_ff @(posedge clk) begin
      for (int j = 1; j < 32; j++) begin
         if (!rst_n) begin
            gpr_q[j] <= '0;
         end else if (w0v[j] || w1v[j]) begin
            // ports never hit the same entry, so or-merge is safe
            gpr_q[j] <= ({`MINI_RV_XLEN{w0v[j]}} & wd0) | ({`MINI_RV_XLEN{w1v[j]}} & wd1);
         end
      end
   end

endmodule

//--- hdl/host_regs.sv
// axi4-lite slave with instruction issue, gpr poke/peek and status counters
`timescale 1ns/100ps
`include "mini_rv_defines.svh"

module host_regs (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [`MINI_RV_AXI_AW-1:0] awaddr,
   input  logic                       awvalid,
   output logic                       awready,
   input  logic [`MINI_RV_XLEN-1:0]   wdata,
   input  logic [3:0]                 wstrb,
   input  logic                       wvalid,
   output logic                       wready,
   output logic [1:0]                 bresp,
   output logic                       bvalid,
   input  logic                       bready,
   input  logic [`MINI_RV_AXI_AW-1:0] araddr,
   input  logic                       arvalid,
   output logic                       arready,
   output logic [`MINI_RV_XLEN-1:0]   rdata,
   output logic [1:0]                 rresp,
   output logic                       rvalid,
   input  logic                       rready,
   output logic                       issue_valid,
   output logic [`MINI_RV_XLEN-1:0]   issue_instr,
   output logic [`MINI_RV_RA_W-1:0]   peek_addr,
   input  logic [`MINI_RV_XLEN-1:0]   rd1,
   output logic                       wen1,
   output logic [`MINI_RV_RA_W-1:0]   waddr1,
   output logic [`MINI_RV_XLEN-1:0]   wd1,
   input  logic                       retire_valid,
   input  logic                       retire_illegal
);

   logic                     busy;
   logic                     wr_hold;
   logic                     wr_go;
   logic                     rd_go;
   logic                     wr_full;
   logic                     wr_idx;
   logic [1:0]               inflight;    // at most two in the pipe
   logic [`MINI_RV_RA_W-1:0] gpr_idx;
   logic [7:0]               retired_cnt;
   logic [7:0]               illegal_cnt;
   logic [`MINI_RV_XLEN-1:0] rd_word;
   logic                     rd_err;

   assign busy    = (inflight != 2'd0);
   // pokes wait for an empty pipe, keeps wen0 and wen1 apart
   assign wr_hold = busy && (awaddr == `MINI_RV_REG_GPR_DATA);
   assign wr_go   = awvalid && wvalid && !bvalid && !wr_hold;
   assign rd_go   = arvalid && !rvalid && !wr_go;  // write wins a tie
   assign awready = wr_go;
   assign wready  = wr_go;
   assign arready = rd_go;
   assign wr_full = &wstrb;  // partial writes rejected

   assign issue_valid = wr_go && wr_full && (awaddr == `MINI_RV_REG_INSTR);
   assign wr_idx      = wr_go && wr_full && (awaddr == `MINI_RV_REG_GPR_IDX);
   assign wen1        = wr_go && wr_full && (awaddr == `MINI_RV_REG_GPR_DATA);
   assign issue_instr = wdata;
   assign waddr1      = gpr_idx;
   assign wd1         = wdata;
   assign peek_addr   = gpr_idx;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         inflight    <= 2'd0;
         gpr_idx     <= '0;
         retired_cnt <= 8'd0;
         illegal_cnt <= 8'd0;
      end else begin
         inflight <= inflight + {1'b0, issue_valid} - {1'b0, retire_valid};
         if (wr_idx) gpr_idx <= wdata[`MINI_RV_RA_W-1:0];
         if (retire_valid) retired_cnt <= retired_cnt + 8'd1;    // wraps
         if (retire_illegal) illegal_cnt <= illegal_cnt + 8'd1;
      end
   end

   // read mux, instr is write only
   always_comb begin
      rd_word = '0;
      rd_err  = 1'b0;
      case (araddr)
         `MINI_RV_REG_GPR_IDX:  rd_word[`MINI_RV_RA_W-1:0] = gpr_idx;
         `MINI_RV_REG_GPR_DATA: rd_word = rd1;  // peek via port 1
         `MINI_RV_REG_STATUS:   rd_word = {8'h00, retired_cnt, illegal_cnt, 7'b0, busy};
         default:               rd_err = 1'b1;
      endcase
   end

   // response handshakes
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bvalid <= 1'b0;
         rvalid <= 1'b0;
      end else begin
         if (wr_go) bvalid <= 1'b1;
         else if (bready) bvalid <= 1'b0;
         if (rd_go) rvalid <= 1'b1;
         else if (rready) rvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_go) begin
         bresp <= (issue_valid || wr_idx || wen1) ? mini_rv_pkg::RESP_OKAY
                                                 : mini_rv_pkg::RESP_SLVERR;
      end
      if (rd_go) begin
         rdata <= rd_word;
         rresp <= rd_err ? mini_rv_pkg::RESP_SLVERR : mini_rv_pkg::RESP_OKAY;
      end
   end

endmodule

//--- hdl/mini_rv_pkg.sv
// instruction word views, alu operation codes and axi response codes
package mini_rv_pkg;

   // one instruction word, two field layouts
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r;                         // register-register
      struct packed {
         logic [11:0] imm12;       // signed immediate, shamt in low bits
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } i;                         // register-immediate
   } rv_instr_u;

   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_AND  = 4'd2,
      ALU_OR   = 4'd3,
      ALU_XOR  = 4'd4,
      ALU_SLL  = 4'd5,
      ALU_SRL  = 4'd6,
      ALU_SRA  = 4'd7,
      ALU_SLT  = 4'd8,
      ALU_SLTU = 4'd9
   } alu_op_e;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_SLVERR = 2'b10
   } axi_resp_e;

endpackage

//--- hdl/mini_rv_top.sv
// top level: host register block, decode, execute and register file
`timescale 1ns/100ps
`include "mini_rv_defines.svh"

module mini_rv_top (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [`MINI_RV_AXI_AW-1:0] awaddr,
   input  logic                       awvalid,
   output logic                       awready,
   input  logic [`MINI_RV_XLEN-1:0]   wdata,
   input  logic [3:0]                 wstrb,
   input  logic                       wvalid,
   output logic                       wready,
   output logic [1:0]                 bresp,
   output logic                       bvalid,
   input  logic                       bready,
   input  logic [`MINI_RV_AXI_AW-1:0] araddr,
   input  logic                       arvalid,
   output logic                       arready,
   output logic [`MINI_RV_XLEN-1:0]   rdata,
   output logic [1:0]                 rresp,
   output logic                       rvalid,
   input  logic                       rready
);

   logic                     issue_valid;
   logic [`MINI_RV_XLEN-1:0] issue_instr;
   logic [`MINI_RV_RA_W-1:0] peek_addr;
   logic [`MINI_RV_RA_W-1:0] raddr0, raddr1;
   logic [`MINI_RV_XLEN-1:0] rd0, rd1;
   logic                     wen0, wen1;        // write-back, poke
   logic [`MINI_RV_RA_W-1:0] waddr0, waddr1;
   logic [`MINI_RV_XLEN-1:0] wd0, wd1;
   logic                     ex_valid, ex_illegal;
   mini_rv_pkg::alu_op_e     ex_op;
   logic [`MINI_RV_XLEN-1:0] ex_a, ex_b;
   logic [`MINI_RV_RA_W-1:0] ex_rd;
   logic                     retire_valid, retire_illegal;

   host_regs i_host_regs (.*);  // bus side, issue and poke

   rv_decode i_rv_decode (.*);  // stage 1

   rv_alu i_rv_alu (.*);        // stage 2, drives write port 0

   gpr_ctl i_gpr_ctl (
      .clk    (clk),
      .rst_n  (rst_n),
      .raddr0 (raddr0),
      .raddr1 (raddr1),
      .wen0   (wen0),
      .waddr0 (waddr0),
      .wd0    (wd0),
      .wen1   (wen1),
      .waddr1 (waddr1),
      .wd1    (wd1),
      .rd0    (rd0),
      .rd1    (rd1)
   );

endmodule

//--- hdl/rv_alu.sv
// execute stage: alu and write-back / retire registers
`timescale 1ns/100ps
`include "mini_rv_defines.svh"

module rv_alu (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     ex_valid,
   input  mini_rv_pkg::alu_op_e     ex_op,
   input  logic [`MINI_RV_XLEN-1:0] ex_a,
   input  logic [`MINI_RV_XLEN-1:0] ex_b,
   input  logic [`MINI_RV_RA_W-1:0] ex_rd,
   input  logic                     ex_illegal,
   output logic                     wen0,
   output logic [`MINI_RV_RA_W-1:0] waddr0,
   output logic [`MINI_RV_XLEN-1:0] wd0,
   output logic                     retire_valid,
   output logic                     retire_illegal
);

   logic [`MINI_RV_XLEN-1:0] result;
   logic [4:0]               shamt;

   assign shamt = ex_b[4:0];  // rv32 shift amount

   always_comb begin
      case (ex_op)
         mini_rv_pkg::ALU_SUB:  result = ex_a - ex_b;
         mini_rv_pkg::ALU_AND:  result = ex_a & ex_b;
         mini_rv_pkg::ALU_OR:   result = ex_a | ex_b;
         mini_rv_pkg::ALU_XOR:  result = ex_a ^ ex_b;
         mini_rv_pkg::ALU_SLL:  result = ex_a << shamt;
         mini_rv_pkg::ALU_SRL:  result = ex_a >> shamt;
         mini_rv_pkg::ALU_SRA:  result = $signed(ex_a) >>> shamt;
         mini_rv_pkg::ALU_SLT:  result = {31'b0, $signed(ex_a) < $signed(ex_b)};
         mini_rv_pkg::ALU_SLTU: result = {31'b0, ex_a < ex_b};
         default:               result = ex_a + ex_b;  // add
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wen0           <= 1'b0;
         retire_valid   <= 1'b0;
         retire_illegal <= 1'b0;
      end else begin
         wen0           <= ex_valid && !ex_illegal && (ex_rd != '0);  // no x0 write
         retire_valid   <= ex_valid;                // legal or not
         retire_illegal <= ex_valid && ex_illegal;
      end
   end

   always_ff @(posedge clk) begin
      waddr0 <= ex_rd;
      wd0    <= result;
   end

endmodule

//--- hdl/rv_decode.sv
// decode stage: field split, operand read with write-back forward, ex regs
`timescale 1ns/100ps
`include "mini_rv_defines.svh"

module rv_decode (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     issue_valid,
   input  logic [`MINI_RV_XLEN-1:0] issue_instr,
   input  logic [`MINI_RV_RA_W-1:0] peek_addr,
   output logic [`MINI_RV_RA_W-1:0] raddr0,
   output logic [`MINI_RV_RA_W-1:0] raddr1,
   input  logic [`MINI_RV_XLEN-1:0] rd0,
   input  logic [`MINI_RV_XLEN-1:0] rd1,
   input  logic                     wen0,      // write-back stage, for forwarding
   input  logic [`MINI_RV_RA_W-1:0] waddr0,
   input  logic [`MINI_RV_XLEN-1:0] wd0,
   output logic                     ex_valid,
   output mini_rv_pkg::alu_op_e     ex_op,
   output logic [`MINI_RV_XLEN-1:0] ex_a,
   output logic [`MINI_RV_XLEN-1:0] ex_b,
   output logic [`MINI_RV_RA_W-1:0] ex_rd,
   output logic                     ex_illegal
);

   mini_rv_pkg::rv_instr_u  instr;
   mini_rv_pkg::alu_op_e    op;
   logic                    illegal;
   logic                    is_imm;
   logic [`MINI_RV_XLEN-1:0] imm_sext;
   logic [`MINI_RV_XLEN-1:0] src_a;
   logic [`MINI_RV_XLEN-1:0] src_b;

   assign instr = issue_instr;
   assign raddr0 = instr.r.rs1;
   assign raddr1 = issue_valid ? instr.r.rs2 : peek_addr;  // port 1 shared with peek
   assign imm_sext = {{(`MINI_RV_XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};

   always_comb begin
      op      = mini_rv_pkg::ALU_ADD;
      illegal = 1'b0;
      is_imm  = 1'b0;
      case (instr.r.opcode)
         `MINI_RV_OPC_OP: begin
            // funct7 0x20 only legal for sub and sra
            illegal = (instr.r.funct7 != 7'h00) &&
                      !((instr.r.funct7 == 7'h20) &&
                        ((instr.r.funct3 == 3'b000) || (instr.r.funct3 == 3'b101)));
            case (instr.r.funct3)
               3'b000: op = instr.r.funct7[5] ? mini_rv_pkg::ALU_SUB : mini_rv_pkg::ALU_ADD;
               3'b001: op = mini_rv_pkg::ALU_SLL;
               3'b010: op = mini_rv_pkg::ALU_SLT;
               3'b011: op = mini_rv_pkg::ALU_SLTU;
               3'b100: op = mini_rv_pkg::ALU_XOR;
               3'b101: op = instr.r.funct7[5] ? mini_rv_pkg::ALU_SRA : mini_rv_pkg::ALU_SRL;
               3'b110: op = mini_rv_pkg::ALU_OR;
               default: op = mini_rv_pkg::ALU_AND;
            endcase
         end
         `MINI_RV_OPC_OP_IMM: begin
            is_imm = 1'b1;
            case (instr.i.funct3)
               3'b000: op = mini_rv_pkg::ALU_ADD;
               3'b001: begin
                  op      = mini_rv_pkg::ALU_SLL;
                  illegal = (instr.i.imm12[11:5] != 7'h00);  // shamt only
               end
               3'b010: op = mini_rv_pkg::ALU_SLT;
               3'b011: op = mini_rv_pkg::ALU_SLTU;
               3'b100: op = mini_rv_pkg::ALU_XOR;
               3'b101: begin
                  op = instr.i.imm12[10] ? mini_rv_pkg::ALU_SRA : mini_rv_pkg::ALU_SRL;
                  illegal = (instr.i.imm12[11:5] != 7'h00) && (instr.i.imm12[11:5] != 7'h20);
               end
               3'b110: op = mini_rv_pkg::ALU_OR;
               default: op = mini_rv_pkg::ALU_AND;
            endcase
         end
         default: illegal = 1'b1;  // everything else unsupported
      endcase
   end

   // wen0 is never set for x0, so no zero check needed here
   assign src_a = (wen0 && (waddr0 == instr.r.rs1)) ? wd0 : rd0;
   assign src_b = is_imm ? imm_sext :
                  (wen0 && (waddr0 == instr.r.rs2)) ? wd0 : rd1;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_valid <= 1'b0;
      end else begin
         ex_valid <= issue_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (issue_valid) begin
         ex_op      <= op;
         ex_a       <= src_a;
         ex_b       <= src_b;
         ex_rd      <= instr.r.rd;
         ex_illegal <= illegal;
      end
   end

endmodule

//--- include/mini_rv_defines.svh
// widths, opcodes and register offsets for the rv32i execution slice
`ifndef MINI_RV_DEFINES_SVH
`define MINI_RV_DEFINES_SVH

// data path and register file
`define MINI_RV_XLEN 32          // integer register width
`define MINI_RV_RA_W 5           // gpr index width

// host bus
`define MINI_RV_AXI_AW 8         // byte address width of the register block

// register offsets
`define MINI_RV_REG_INSTR    8'h00  // write only, issues one instruction
`define MINI_RV_REG_GPR_IDX  8'h04  // selects the gpr for poke and peek
`define MINI_RV_REG_GPR_DATA 8'h08  // poke on write, peek on read
`define MINI_RV_REG_STATUS   8'h0C  // busy and counters, read only

// supported major opcodes
`define MINI_RV_OPC_OP     7'h33  // register-register alu
`define MINI_RV_OPC_OP_IMM 7'h13  // register-immediate alu

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
log=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
      -f flist.f --top-module tb_mini_rv -Mdir obj_dir -o tb_mini_rv; then
   echo "verilator build failed"
   exit 1
fi

if ! ./obj_dir/tb_mini_rv > "$log" 2>&1; then
   cat "$log"
   echo "simulation exited with an error"
   exit 1
fi
cat "$log"

if grep -qx "All checks passed" "$log"; then
   exit 0
fi
exit 1

//--- testbench/tb_mini_rv.sv
// directed testbench for the rv32i slice: axi4-lite driver tasks,
// register file reference model and per-feature tests
`timescale 1ns/100ps
`include "mini_rv_defines.svh"

module tb_mini_rv;

   localparam int TMO = 40;  // cycles allowed per handshake wait
   // r-type table, entry k at bits 3k+2..3k: add sub sll slt sltu xor srl sra or and
   localparam logic [29:0] RR_F3  = {3'd7, 3'd6, 3'd5, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0, 3'd0};
   localparam logic [9:0]  RR_ALT = 10'b0010000010;  // sub and sra take funct7 0x20

   logic        clk, rst_n;
   logic [7:0]  awaddr, araddr;
   logic        awvalid, wvalid, bready, arvalid, rready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        awready, wready, bvalid, arready, rvalid;
   logic [1:0]  bresp, rresp;
   logic [31:0] rdata;

   logic [31:0] model [0:31];   // expected gpr contents
   integer      seed;
   int          errors, checks;
   int          n_retired, n_illegal;
   bit          hung;           // set by a stalled wait

   mini_rv_top i_dut (.*);

   always #50 clk = ~clk;

   // isa reference for one alu operation
   function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'd0: return alt ? a - b : a + b;
         3'd1: return a << b[4:0];
         3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'd3: return (a < b) ? 32'd1 : 32'd0;
         3'd4: return a ^ b;
         3'd5: begin
            if (alt) return $signed(a) >>> b[4:0];  // arithmetic
            return a >> b[4:0];
         end
         3'd6: return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'h33};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
      return {imm, rs1, f3, rd, 7'h13};
   endfunction

   // applies one issued word to the model and the retire counts
   task automatic model_exec(input logic [31:0] ins);
      logic [6:0]  opc, f7;
      logic [2:0]  f3;
      logic [31:0] a, b;
      logic        legal, alt;
      opc   = ins[6:0];
      f3    = ins[14:12];
      f7    = ins[31:25];
      a     = model[ins[19:15]];
      b     = model[ins[24:20]];
      alt   = f7[5];
      legal = 1'b0;
      if (opc == 7'h33) begin
         legal = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
      end else if (opc == 7'h13) begin
         b     = {{20{ins[31]}}, ins[31:20]};
         alt   = (f3 == 3'd5) && ins[30];  // no subi
         legal = (f3 == 3'd1) ? (f7 == 7'h00) :
                 (f3 == 3'd5) ? ((f7 == 7'h00) || (f7 == 7'h20)) : 1'b1;
      end
      n_retired++;
      if (!legal) n_illegal++;
      else if (ins[11:7] != 5'd0) model[ins[11:7]] = alu_ref(f3, alt, a, b);
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("Fail %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic report_stall(input string what);
      $display("timeout: %s", what);
      hung = 1'b1;
      forever @(posedge clk);  // watchdog ends the run
   endtask

   task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp, output int waited);
      int n;
      @(posedge clk);
      awaddr  <= addr;
      wdata   <= data;
      wstrb   <= 4'hf;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      bready  <= 1'b1;
      n = 0;
      @(negedge clk);
      while (!(awready && wready)) begin  // held off while busy on gpr_data
         n++;
         if (n > TMO) report_stall("write address and data channels were never accepted");
         @(negedge clk);
      end
      waited = n;
      @(posedge clk);  // accept edge
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      n = 0;
      @(negedge clk);
      while (!bvalid) begin
         n++;
         if (n > TMO) report_stall("write response channel never returned bvalid");
         @(negedge clk);
      end
      resp = bresp;
   endtask

   task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
      int n;
      @(posedge clk);
      araddr  <= addr;
      arvalid <= 1'b1;
      rready  <= 1'b1;
      n = 0;
      @(negedge clk);
      while (!arready) begin
         n++;
         if (n > TMO) report_stall("read address channel was never accepted");
         @(negedge clk);
      end
      @(posedge clk);
      arvalid <= 1'b0;
      n = 0;
      @(negedge clk);
      while (!rvalid) begin
         n++;
         if (n > TMO) report_stall("read data channel never returned rvalid");
         @(negedge clk);
      end
      data = rdata;
      resp = rresp;
   endtask

   task automatic write_ok(input logic [7:0] addr, input logic [31:0] data);
      logic [1:0] resp;
      int         waited;
      axil_write(addr, data, resp, waited);
      check_val("bresp", {30'b0, resp}, 32'h0);
   endtask

   task automatic read_ok(input logic [7:0] addr, output logic [31:0] data);
      logic [1:0] resp;
      axil_read(addr, data, resp);
      check_val("rresp", {30'b0, resp}, 32'h0);
   endtask

   task automatic poke(input logic [4:0] idx, input logic [31:0] val);
      write_ok(`MINI_RV_REG_GPR_IDX, {27'b0, idx});
      write_ok(`MINI_RV_REG_GPR_DATA, val);
      if (idx != 5'd0) model[idx] = val;  // x0 stays zero
   endtask

   task automatic peek(input logic [4:0] idx, output logic [31:0] val);
      write_ok(`MINI_RV_REG_GPR_IDX, {27'b0, idx});
      read_ok(`MINI_RV_REG_GPR_DATA, val);
   endtask

   task automatic issue(input logic [31:0] ins);
      write_ok(`MINI_RV_REG_INSTR, ins);
      model_exec(ins);
   endtask

   task automatic wait_idle;
      logic [31:0] st;
      int          n;
      n = 0;
      read_ok(`MINI_RV_REG_STATUS, st);
      while (st[0]) begin
         n++;
         if (n > TMO) report_stall("busy flag in status never cleared");
         read_ok(`MINI_RV_REG_STATUS, st);
      end
   endtask

   task automatic check_all_regs;
      logic [31:0] got;
      for (int r = 0; r < 32; r++) begin
         peek(5'(r), got);
         check_val($sformatf("x%0d", r), got, model[r]);
      end
   endtask

   task automatic check_status;
      logic [31:0] st;
      read_ok(`MINI_RV_REG_STATUS, st);
      check_val("status", st, {8'h00, 8'(n_retired), 8'(n_illegal), 8'h00});
   endtask

   task automatic test_poke_peek;
      logic [31:0] rnd;
      for (int r = 0; r < 32; r++) begin
         rnd = $random(seed);
         poke(5'(r), rnd);
      end
      check_all_regs();  // x0 must read zero
   endtask

   task automatic test_alu_rr;
      logic [31:0] rnd, got;
      for (int k = 0; k < 10; k++) begin
         rnd = $random(seed);
         poke(5'(k + 1), rnd);
         rnd = $random(seed);
         poke(5'(k + 12), rnd);
         issue(enc_r(RR_ALT[k] ? 7'h20 : 7'h00, 5'(k + 12), 5'(k + 1),
                     RR_F3[k*3 +: 3], 5'(k + 21)));
         wait_idle();
         peek(5'(k + 21), got);
         check_val($sformatf("x%0d", k + 21), got, model[k + 21]);
      end
   endtask

   task automatic test_imm_fwd;
      logic [31:0] rnd, got;
      logic [4:0]  src, rd;
      rnd = $random(seed);
      poke(5'd5, rnd);
      src = 5'd5;
      for (int k = 0; k < 8; k++) begin  // each one reads the previous result
         rnd = $random(seed);
         rd  = 5'(6 + k % 3);
         issue(enc_i(rnd[11:0], src, (k % 2 != 0) ? 3'b100 : 3'b000, rd));
         src = rd;
      end
      wait_idle();
      for (int r = 5; r < 9; r++) begin
         peek(5'(r), got);
         check_val($sformatf("x%0d", r), got, model[r]);
      end
   endtask

   task automatic test_illegal_x0;
      issue({12'h003, 5'd2, 3'b010, 5'd3, 7'h03});          // lw, unsupported
      issue(enc_r(7'h01, 5'd4, 5'd5, 3'b000, 5'd6));         // mul encoding
      issue(enc_i(12'h400, 5'd7, 3'b001, 5'd8));             // slli, bad shamt field
      issue(enc_i(12'h055, 5'd1, 3'b000, 5'd0));             // addi to x0
      wait_idle();
      check_status();
      check_all_regs();
   endtask

   task automatic test_bus_err;
      logic [1:0]  resp;
      logic [31:0] d, rnd;
      int          waited;
      axil_write(`MINI_RV_REG_STATUS, 32'hffff_ffff, resp, waited);
      check_val("bresp", {30'b0, resp}, 32'h2);
      axil_write(8'h20, 32'h1234_5678, resp, waited);        // unmapped
      check_val("bresp", {30'b0, resp}, 32'h2);
      axil_read(8'h24, d, resp);
      check_val("rdata", d, 32'h0);
      check_val("rresp", {30'b0, resp}, 32'h2);
      check_status();
      check_all_regs();
      // poke right behind an issue to the same register
      write_ok(`MINI_RV_REG_GPR_IDX, 32'd9);
      issue(enc_i(12'h123, 5'd9, 3'b000, 5'd9));
      rnd = $random(seed);
      axil_write(`MINI_RV_REG_GPR_DATA, rnd, resp, waited);
      check_val("bresp", {30'b0, resp}, 32'h0);
      checks++;
      assert (waited > 0) else begin
         $display("poke to gpr_data was accepted while the pipeline was busy");
         errors++;
      end
      model[9] = rnd;  // poke lands after the write-back
      wait_idle();
      peek(5'd9, d);
      check_val("x9", d, model[9]);
   endtask

   task automatic report_test(input string name, input int e0);
      $display("test %s: %s, %0d errors", name, (errors == e0) ? "ok" : "mismatches",
               errors - e0);
   endtask

   // ends the run when a handshake stalls
   initial begin
      wait (hung);
      $display("Checks failed");
      $finish;
   end

   initial begin
      int e0;
      clk     = 1'b0;
      rst_n   = 1'b0;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      seed    = 32'h81f9;
      errors  = 0;
      checks  = 0;
      n_retired = 0;
      n_illegal = 0;
      for (int r = 0; r < 32; r++) model[r] = '0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      e0 = errors;
      test_poke_peek();
      report_test("poke_peek", e0);
      e0 = errors;
      test_alu_rr();
      report_test("alu_rr", e0);
      e0 = errors;
      test_imm_fwd();
      report_test("imm_fwd", e0);
      e0 = errors;
      test_illegal_x0();
      report_test("illegal_x0", e0);
      e0 = errors;
      test_bus_err();
      report_test("bus_err", e0);
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule
